//--- tb.f
verilog/bpu_pkg.sv
verilog/local_history_predictor.sv
verilog/branch_target_buffer.sv
verilog/return_address_stack.sv
verilog/indirect_target_cache.sv
verilog/branch_predictor.sv
bench/bench_clock.sv
bench/bpu_assertions.sv
bench/bpu_tb.sv

//--- Bender.yml
package:
  name: branch_predictor

sources:
  - files:
      - verilog/bpu_pkg.sv
      - verilog/local_history_predictor.sv
      - verilog/branch_target_buffer.sv
      - verilog/return_address_stack.sv
      - verilog/indirect_target_cache.sv
      - verilog/branch_predictor.sv
  - target: test
    files:
      - bench/bench_clock.sv
      - bench/bpu_assertions.sv
      - bench/bpu_tb.sv

//--- bench/bpu_tb.sv
`timescale 1ns/1ns

module bpu_tb import bpu_pkg::*; ();

    localparam int BTB_ENTRIES = 64;
    localparam int HIST_ENTRIES = 32;
    localparam int HIST_LEN = 6;
    localparam int RAS_DEPTH = 16;
    localparam int RAS_CNT_W = 8;
    localparam int BIDX_W = $clog2(BTB_ENTRIES);
    localparam int HIDX_W = $clog2(HIST_ENTRIES);
    localparam int RESET_CYCLES = 8;

    typedef enum {op_fetch, op_peek, op_mispredict, op_resolve} op_t;

    typedef struct {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        branch_kind_t      kind;
        logic [ADDR_W-1:0] data;
        logic [ADDR_W-1:0] exp_pc;
        logic [1:0]        exp_hit;
        string             name;
    } row_t;

    logic clk;
    logic reset;
    logic fetch_valid_i;
    logic [ADDR_W-1:0] fetch_pc_i;
    logic mispredict_i;
    logic [ADDR_W-1:0] wrong_pc_i;
    branch_kind_t wrong_kind_i;
    logic [ADDR_W-1:0] right_target_i;
    logic resolve_i;
    logic [ADDR_W-1:0] retire_pc_i;
    logic taken_i;
    logic [ADDR_W-1:0] next_pc_o;
    logic [1:0] hit_slot_o;

    row_t stim_q[$];
    logic [31:0] rng_state = 32'd49;
    int cycle_count = 0;
    int timeout_limit = 1000;

    // model of the tables
    logic                  m_valid [BTB_ENTRIES];
    logic [ADDR_W-1:0]     m_tag [BTB_ENTRIES];
    branch_kind_t          m_kind [BTB_ENTRIES];
    logic [ADDR_W-1:0]     m_target [BTB_ENTRIES];
    logic [HIST_LEN-1:0]   m_hist [HIST_ENTRIES];
    logic [CTR_W-1:0]      m_pht [2**HIST_LEN];
    logic [ADDR_W-1:0]     m_itc [2**HIST_LEN];
    logic [ADDR_W-1:0]     m_ras_addr [RAS_DEPTH];
    int                    m_ras_cnt [RAS_DEPTH];
    int                    m_ras_ptr;

    bench_clock #(.PERIOD_NS(4)) i_bench_clock (.clk_o(clk));

    branch_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .HIST_ENTRIES(HIST_ENTRIES),
        .HIST_LEN    (HIST_LEN),
        .RAS_DEPTH   (RAS_DEPTH),
        .RAS_CNT_W   (RAS_CNT_W)
    ) i_branch_predictor (
        .clk           (clk),
        .reset         (reset),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .mispredict_i  (mispredict_i),
        .wrong_pc_i    (wrong_pc_i),
        .wrong_kind_i  (wrong_kind_i),
        .right_target_i(right_target_i),
        .resolve_i     (resolve_i),
        .retire_pc_i   (retire_pc_i),
        .taken_i       (taken_i),
        .next_pc_o     (next_pc_o),
        .hit_slot_o    (hit_slot_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [HIST_LEN-1:0] model_hash(input logic [ADDR_W-1:0] pc);
        return m_hist[pc[HIST_LEN+2 +: HIDX_W]] ^ pc[HIST_LEN+2:3];
    endfunction

    function automatic branch_kind_t model_kind(input logic [ADDR_W-1:0] pc);
        logic [BIDX_W-1:0] idx;
        idx = pc[2 +: BIDX_W];
        if (m_valid[idx] && m_tag[idx] == (pc >> (BIDX_W + 2))) begin
            return m_kind[idx];
        end
        return br_none;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < HIST_ENTRIES; i++) begin
            m_hist[i] = '0;
        end
        for (int i = 0; i < 2**HIST_LEN; i++) begin
            m_pht[i] = '0;
            m_itc[i] = '0;
        end
        for (int i = 0; i < RAS_DEPTH; i++) begin
            m_ras_addr[i] = '0;
            m_ras_cnt[i] = 0;
        end
        m_ras_ptr = 0;
    endtask

    task automatic add_fetch(input string name, input logic [ADDR_W-1:0] pc, input bit valid);
        row_t row;
        branch_kind_t kind [2];
        bit redirect [2];
        int sel;
        logic [ADDR_W-1:0] slot_pc;
        for (int s = 0; s < 2; s++) begin
            slot_pc = pc + 4 * s;
            kind[s] = model_kind(slot_pc);
            redirect[s] = kind[s] != br_none &&
                (kind[s] != br_cond || m_pht[model_hash(slot_pc)][CTR_W-1]);
        end
        sel = redirect[0] ? 0 : 1;
        slot_pc = pc + 4 * sel;
        row = '{op: valid ? op_fetch : op_peek, addr: pc, kind: br_none, data: '0,
                exp_pc: pc + 8, exp_hit: 2'b00, name: name};
        if (redirect[0] || redirect[1]) begin
            row.exp_hit = redirect[0] ? 2'b01 : 2'b10;
            case (kind[sel])
                br_ret:      row.exp_pc = m_ras_addr[m_ras_ptr];
                br_indirect: row.exp_pc = m_itc[model_hash(slot_pc)];
                default:     row.exp_pc = m_target[slot_pc[2 +: BIDX_W]];
            endcase
            // stack moves only for a valid fetch
            if (valid && kind[sel] == br_call) begin
                if (m_ras_cnt[m_ras_ptr] == 0) begin
                    m_ras_addr[m_ras_ptr] = slot_pc + 4;
                    m_ras_cnt[m_ras_ptr] = 1;
                end else if (m_ras_addr[m_ras_ptr] == slot_pc + 4 &&
                             m_ras_cnt[m_ras_ptr] < 2**RAS_CNT_W - 1) begin
                    m_ras_cnt[m_ras_ptr]++;
                end else begin
                    m_ras_ptr = (m_ras_ptr + 1) % RAS_DEPTH;
                    m_ras_addr[m_ras_ptr] = slot_pc + 4;
                    m_ras_cnt[m_ras_ptr] = 1;
                end
            end else if (valid && kind[sel] == br_ret) begin
                if (m_ras_cnt[m_ras_ptr] <= 1) begin
                    m_ras_cnt[m_ras_ptr] = 0;
                    m_ras_ptr = (m_ras_ptr + RAS_DEPTH - 1) % RAS_DEPTH;
                end else begin
                    m_ras_cnt[m_ras_ptr]--;
                end
            end
        end
        stim_q.push_back(row);
    endtask

    task automatic add_mispredict(input string name, input logic [ADDR_W-1:0] pc,
                                  input branch_kind_t kind, input logic [ADDR_W-1:0] target);
        logic [BIDX_W-1:0] idx;
        idx = pc[2 +: BIDX_W];
        m_valid[idx] = 1'b1;
        m_tag[idx] = pc >> (BIDX_W + 2);
        m_kind[idx] = kind;
        m_target[idx] = target;
        if (kind == br_indirect) begin
            m_itc[model_hash(pc)] = target;
        end
        stim_q.push_back('{op_mispredict, pc, kind, target, '0, 2'b00, name});
    endtask

    task automatic add_resolve(input string name, input logic [ADDR_W-1:0] pc, input bit taken);
        logic [HIST_LEN-1:0] h;
        logic [HIDX_W-1:0] hidx;
        h = model_hash(pc);
        hidx = pc[HIST_LEN+2 +: HIDX_W];
        if (taken && m_pht[h] != '1) begin
            m_pht[h]++;
        end else if (!taken && m_pht[h] != '0) begin
            m_pht[h]--;
        end
        m_hist[hidx] = {m_hist[hidx][HIST_LEN-2:0], taken};
        stim_q.push_back('{op_resolve, pc, br_none, ADDR_W'(taken), '0, 2'b00, name});
    endtask

    task automatic add_random_fetches(input string name, input int count);
        for (int i = 0; i < count; i++) begin
            rng_state = xorshift(rng_state);
            add_fetch(name, rng_state & ~32'h7, 1'b1);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_row(input row_t row);
        fetch_valid_i <= (row.op == op_fetch);
        mispredict_i <= (row.op == op_mispredict);
        resolve_i <= (row.op == op_resolve);
        if (row.op == op_fetch || row.op == op_peek) begin
            fetch_pc_i <= row.addr;
        end
        if (row.op == op_mispredict) begin
            wrong_pc_i <= row.addr;
            wrong_kind_i <= row.kind;
            right_target_i <= row.data;
        end
        if (row.op == op_resolve) begin
            retire_pc_i <= row.addr;
            taken_i <= row.data[0];
        end
    endtask

    task automatic build_table();
        model_reset();
        add_random_fetches("reset fall-through", 8);
        add_mispredict("install slot 1 direct", 32'h0000_1004, br_direct, 32'h0000_2000);
        add_fetch("slot 1 direct", 32'h0000_1000, 1'b1);
        add_mispredict("install slot 0 direct", 32'h0000_1000, br_direct, 32'h0000_3000);
        add_fetch("slot 0 priority", 32'h0000_1000, 1'b1);
        add_mispredict("install cond", 32'h0000_4000, br_cond, 32'h0000_4800);
        add_fetch("cond untrained", 32'h0000_4000, 1'b1);
        // runs past the top of the counter once history is all ones
        for (int k = 0; k < 10; k++) begin
            add_resolve("cond train up", 32'h0000_4000, 1'b1);
            add_fetch("cond after taken", 32'h0000_4000, 1'b1);
        end
        // runs below zero once history is all zeros
        for (int k = 0; k < 8; k++) begin
            add_resolve("cond train down", 32'h0000_4000, 1'b0);
            add_fetch("cond after not taken", 32'h0000_4000, 1'b1);
        end
        add_mispredict("install call", 32'h0000_5000, br_call, 32'h0000_6000);
        add_mispredict("install ret", 32'h0000_6008, br_ret, 32'h0000_0000);
        add_mispredict("install slot 1 call", 32'h0000_7004, br_call, 32'h0000_6000);
        add_fetch("call", 32'h0000_5000, 1'b1);
        add_fetch("ret to call site", 32'h0000_6008, 1'b1);
        add_fetch("slot 1 call", 32'h0000_7000, 1'b1);
        add_fetch("first recursive call", 32'h0000_5000, 1'b1);
        add_fetch("second recursive call", 32'h0000_5000, 1'b1);
        add_fetch("call without valid", 32'h0000_5000, 1'b0);
        add_fetch("ret without valid", 32'h0000_6008, 1'b0);
        add_fetch("first recursive ret", 32'h0000_6008, 1'b1);
        add_fetch("second recursive ret", 32'h0000_6008, 1'b1);
        add_fetch("ret to older call", 32'h0000_6008, 1'b1);
        add_mispredict("install indirect", 32'h0000_8000, br_indirect, 32'h8abc_0010);
        add_fetch("indirect same history", 32'h0000_8000, 1'b1);
        add_resolve("indirect history shift", 32'h0000_8000, 1'b1);
        add_fetch("indirect new history", 32'h0000_8000, 1'b1);
        add_random_fetches("late random fetch", 6);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $fatal(1, "run timed out");
        end
    end

    initial begin
        reset = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i = '0;
        mispredict_i = 1'b0;
        wrong_pc_i = '0;
        wrong_kind_i = br_none;
        right_target_i = '0;
        resolve_i = 1'b0;
        retire_pc_i = '0;
        taken_i = 1'b0;
        build_table();
        timeout_limit = (stim_q.size() + RESET_CYCLES) * 2 + 50;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        foreach (stim_q[r]) begin
            @(posedge clk);
            drive_row(stim_q[r]);
            // outputs are settled by mid-cycle
            @(negedge clk);
            if (stim_q[r].op == op_fetch || stim_q[r].op == op_peek) begin
                check_value($sformatf("%s (row %0d) next_pc", stim_q[r].name, r),
                            stim_q[r].exp_pc, next_pc_o);
                check_value($sformatf("%s (row %0d) hit_slot", stim_q[r].name, r),
                            {30'b0, stim_q[r].exp_hit}, {30'b0, hit_slot_o});
            end
        end

        @(posedge clk);
        fetch_valid_i <= 1'b0;
        mispredict_i <= 1'b0;
        resolve_i <= 1'b0;
        repeat (2) @(posedge clk);

        if (i_branch_predictor.i_bpu_assertions.fail_count != 0) begin
            $display("%0d assertion failures",
                     i_branch_predictor.i_bpu_assertions.fail_count);
            $display("TEST FAILED");
            $fatal(1, "assertion checks failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- bench/bpu_assertions.sv
`timescale 1ns/1ns

module bpu_assertions import bpu_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic [ADDR_W-1:0] fetch_pc_i,
    input logic [ADDR_W-1:0] next_pc_i,
    input logic [1:0]        hit_slot_i,
    input logic              push_i,
    input logic              pop_i
);

    int fail_count = 0;

    a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit_slot_i))
        else begin
            $error("hit slot has both bits set");
            fail_count++;
        end

    a_fall_through: assert property (@(posedge clk) disable iff (reset)
        (hit_slot_i == 2'b00) |-> (next_pc_i == fetch_pc_i + ADDR_W'(8)))
        else begin
            $error("no redirect but next pc is not the fall-through address");
            fail_count++;
        end

    // tables are cleared after the first reset edge
    a_reset_quiet: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (hit_slot_i == 2'b00))
        else begin
            $error("redirect reported while in reset");
            fail_count++;
        end

    a_push_pop: assert property (@(posedge clk) disable iff (reset)
        !(push_i && pop_i))
        else begin
            $error("stack push and pop in the same cycle");
            fail_count++;
        end

endmodule

bind branch_predictor bpu_assertions i_bpu_assertions (
    .clk       (clk),
    .reset     (reset),
    .fetch_pc_i(fetch_pc_i),
    .next_pc_i (next_pc_o),
    .hit_slot_i(hit_slot_o),
    .push_i    (push),
    .pop_i     (pop)
);

//--- bench/bench_clock.sv
`timescale 1ns/1ns

module bench_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

//--- verilog/branch_predictor.sv
`timescale 1ns/1ns

module branch_predictor import bpu_pkg::*; #(
    parameter int BTB_ENTRIES = 64,
    parameter int HIST_ENTRIES = 32,
    parameter int HIST_LEN = 6,
    parameter int RAS_DEPTH = 16,
    parameter int RAS_CNT_W = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_valid_i,
    input  logic [ADDR_W-1:0] fetch_pc_i,
    input  logic              mispredict_i,
    input  logic [ADDR_W-1:0] wrong_pc_i,
    input  branch_kind_t      wrong_kind_i,
    input  logic [ADDR_W-1:0] right_target_i,
    input  logic              resolve_i,
    input  logic [ADDR_W-1:0] retire_pc_i,
    input  logic              taken_i,
    output logic [ADDR_W-1:0] next_pc_o,
    output logic [1:0]        hit_slot_o
);

    logic [1:0]                   pred_taken;
    logic [1:0][HIST_LEN-1:0]     slot_hash;
    logic [HIST_LEN-1:0]          wrong_hash;
    branch_kind_t [1:0]           btb_kind;
    logic [1:0][ADDR_W-1:0]       btb_target;
    logic [1:0][ADDR_W-1:0]       itc_target;
    logic [ADDR_W-1:0]            ras_top;

    logic [1:0]                   redirect;
    logic                         sel;
    branch_kind_t                 chosen_kind;
    logic [ADDR_W-1:0]            chosen_pc;
    logic                         push;
    logic                         pop;
    logic                         itc_write;

    local_history_predictor #(
        .HIST_ENTRIES(HIST_ENTRIES),
        .HIST_LEN    (HIST_LEN)
    ) i_local_history_predictor (
        .clk         (clk),
        .reset       (reset),
        .fetch_pc_i  (fetch_pc_i),
        .wrong_pc_i  (wrong_pc_i),
        .resolve_i   (resolve_i),
        .retire_pc_i (retire_pc_i),
        .taken_i     (taken_i),
        .pred_taken_o(pred_taken),
        .slot_hash_o (slot_hash),
        .wrong_hash_o(wrong_hash)
    );

    branch_target_buffer #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) i_branch_target_buffer (
        .clk           (clk),
        .reset         (reset),
        .fetch_pc_i    (fetch_pc_i),
        .write_i       (mispredict_i),
        .write_pc_i    (wrong_pc_i),
        .write_kind_i  (wrong_kind_i),
        .write_target_i(right_target_i),
        .slot_kind_o   (btb_kind),
        .slot_target_o (btb_target)
    );

    return_address_stack #(
        .RAS_DEPTH(RAS_DEPTH),
        .RAS_CNT_W(RAS_CNT_W)
    ) i_return_address_stack (
        .clk        (clk),
        .reset      (reset),
        .push_i     (push),
        .pop_i      (pop),
        .push_addr_i(chosen_pc + ADDR_W'(4)),
        .top_o      (ras_top)
    );

    indirect_target_cache #(
        .HIST_LEN(HIST_LEN)
    ) i_indirect_target_cache (
        .clk           (clk),
        .reset         (reset),
        .read_hash_i   (slot_hash),
        .write_i       (itc_write),
        .write_hash_i  (wrong_hash),
        .write_target_i(right_target_i),
        .slot_target_o (itc_target)
    );

    // conditional branches only redirect when predicted taken
    for (genvar s = 0; s < 2; s++) begin : g_slot
        assign redirect[s] = (btb_kind[s] != br_none) &&
                             ((btb_kind[s] != br_cond) || pred_taken[s]);
    end

    // slot 0 wins
    assign sel = ~redirect[0];
    assign hit_slot_o = {redirect[1] & ~redirect[0], redirect[0]};
    assign chosen_kind = (|redirect) ? btb_kind[sel] : br_none;
    assign chosen_pc = fetch_pc_i + ADDR_W'({sel, 2'b00});

    assign push = fetch_valid_i && (chosen_kind == br_call);
    assign pop = fetch_valid_i && (chosen_kind == br_ret);
    assign itc_write = mispredict_i && (wrong_kind_i == br_indirect);

    always_comb begin
        case (chosen_kind)
            br_cond, br_direct, br_call: next_pc_o = btb_target[sel];
            br_ret:                      next_pc_o = ras_top;
            br_indirect:                 next_pc_o = itc_target[sel];
            default:                     next_pc_o = fetch_pc_i + ADDR_W'(8);
        endcase
    end

endmodule

//--- verilog/indirect_target_cache.sv
`timescale 1ns/1ns

module indirect_target_cache import bpu_pkg::*; #(
    parameter int HIST_LEN = 6
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [1:0][HIST_LEN-1:0]   read_hash_i,
    input  logic                       write_i,
    input  logic [HIST_LEN-1:0]        write_hash_i,
    input  logic [ADDR_W-1:0]          write_target_i,
    output logic [1:0][ADDR_W-1:0]     slot_target_o
);

    localparam int TC_ENTRIES = 2 ** HIST_LEN;

    logic [ADDR_W-1:0] target_q [TC_ENTRIES];

    // no tags, aliasing hashes share an entry
    for (genvar s = 0; s < 2; s++) begin : g_read
        assign slot_target_o[s] = target_q[read_hash_i[s]];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TC_ENTRIES; i++) begin
                target_q[i] <= '0;
            end
        end else if (write_i) begin
            target_q[write_hash_i] <= write_target_i;
        end
    end

endmodule

//--- verilog/return_address_stack.sv
`timescale 1ns/1ns

module return_address_stack import bpu_pkg::*; #(
    parameter int RAS_DEPTH = 16,
    parameter int RAS_CNT_W = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push_i,
    input  logic              pop_i,
    input  logic [ADDR_W-1:0] push_addr_i,
    output logic [ADDR_W-1:0] top_o
);

    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [ADDR_W-1:0]    addr_q [RAS_DEPTH];
    logic [RAS_CNT_W-1:0] cnt_q [RAS_DEPTH];
    logic [PTR_W-1:0]     ptr_q;

    logic [PTR_W-1:0]     ptr_next;
    logic                 top_empty;
    logic                 top_match;
    logic                 top_full;

    assign ptr_next = ptr_q + PTR_W'(1);
    assign top_empty = (cnt_q[ptr_q] == '0);
    assign top_match = (addr_q[ptr_q] == push_addr_i);
    assign top_full = (cnt_q[ptr_q] == {RAS_CNT_W{1'b1}});

    assign top_o = addr_q[ptr_q];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                addr_q[i] <= '0;
                cnt_q[i] <= '0;
            end
            ptr_q <= '0;
        end else if (push_i) begin
            if (top_empty) begin
                addr_q[ptr_q] <= push_addr_i;
                cnt_q[ptr_q] <= RAS_CNT_W'(1);
            end else if (top_match && !top_full) begin
                // recursive call to the same site
                cnt_q[ptr_q] <= cnt_q[ptr_q] + RAS_CNT_W'(1);
            end else begin
                // wraps over the oldest entry when full
                addr_q[ptr_next] <= push_addr_i;
                cnt_q[ptr_next] <= RAS_CNT_W'(1);
                ptr_q <= ptr_next;
            end
        end else if (pop_i) begin
            if (cnt_q[ptr_q] <= RAS_CNT_W'(1)) begin
                cnt_q[ptr_q] <= '0;
                ptr_q <= ptr_q - PTR_W'(1);
            end else begin
                cnt_q[ptr_q] <= cnt_q[ptr_q] - RAS_CNT_W'(1);
            end
        end
    end

endmodule

//--- verilog/branch_target_buffer.sv
`timescale 1ns/1ns

module branch_target_buffer import bpu_pkg::*; #(
    parameter int BTB_ENTRIES = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [ADDR_W-1:0]        fetch_pc_i,
    input  logic                     write_i,
    input  logic [ADDR_W-1:0]        write_pc_i,
    input  branch_kind_t             write_kind_i,
    input  logic [ADDR_W-1:0]        write_target_i,
    output branch_kind_t [1:0]       slot_kind_o,
    output logic [1:0][ADDR_W-1:0]   slot_target_o
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = ADDR_W - IDX_W - 2;

    logic              valid_q [BTB_ENTRIES];
    logic [TAG_W-1:0]  tag_q [BTB_ENTRIES];
    branch_kind_t      kind_q [BTB_ENTRIES];
    logic [ADDR_W-1:0] target_q [BTB_ENTRIES];

    logic [IDX_W-1:0]  write_idx;

    assign write_idx = write_pc_i[2 +: IDX_W];

    // one read port per fetch slot
    for (genvar s = 0; s < 2; s++) begin : g_read
        logic [ADDR_W-1:0] slot_pc;
        logic [IDX_W-1:0]  idx;
        logic              hit;

        assign slot_pc = fetch_pc_i + ADDR_W'(4 * s);
        assign idx = slot_pc[2 +: IDX_W];
        assign hit = valid_q[idx] && (tag_q[idx] == slot_pc[ADDR_W-1 -: TAG_W]);
        // a miss looks like a plain instruction
        assign slot_kind_o[s] = hit ? kind_q[idx] : br_none;
        assign slot_target_o[s] = target_q[idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (write_i) begin
            valid_q[write_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_i) begin
            tag_q[write_idx] <= write_pc_i[ADDR_W-1 -: TAG_W];
            kind_q[write_idx] <= write_kind_i;
            target_q[write_idx] <= write_target_i;
        end
    end

endmodule

//--- verilog/local_history_predictor.sv
`timescale 1ns/1ns

module local_history_predictor import bpu_pkg::*; #(
    parameter int HIST_ENTRIES = 32,
    parameter int HIST_LEN = 6
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [ADDR_W-1:0]              fetch_pc_i,
    input  logic [ADDR_W-1:0]              wrong_pc_i,
    input  logic                           resolve_i,
    input  logic [ADDR_W-1:0]              retire_pc_i,
    input  logic                           taken_i,
    output logic [1:0]                     pred_taken_o,
    output logic [1:0][HIST_LEN-1:0]       slot_hash_o,
    output logic [HIST_LEN-1:0]            wrong_hash_o
);

    localparam int HIDX_W = $clog2(HIST_ENTRIES);
    localparam int PHT_ENTRIES = 2 ** HIST_LEN;

    logic [HIST_LEN-1:0] hist_q [HIST_ENTRIES];
    logic [CTR_W-1:0]    pht_q [PHT_ENTRIES];

    logic [HIDX_W-1:0]   retire_idx;
    logic [HIST_LEN-1:0] retire_hash;

    function automatic logic [HIDX_W-1:0] hist_index(input logic [ADDR_W-1:0] pc);
        hist_index = pc[HIST_LEN+2 +: HIDX_W];
    endfunction

    // local history folded with the low fetch-block bits
    function automatic logic [HIST_LEN-1:0] hash_of(input logic [HIST_LEN-1:0] hist,
                                                     input logic [ADDR_W-1:0] pc);
        hash_of = hist ^ pc[HIST_LEN+2:3];
    endfunction

    for (genvar s = 0; s < 2; s++) begin : g_slot
        logic [ADDR_W-1:0] slot_pc;

        assign slot_pc = fetch_pc_i + ADDR_W'(4 * s);
        assign slot_hash_o[s] = hash_of(hist_q[hist_index(slot_pc)], slot_pc);
        // upper counter bit is the taken guess
        assign pred_taken_o[s] = pht_q[slot_hash_o[s]][CTR_W-1];
    end

    assign wrong_hash_o = hash_of(hist_q[hist_index(wrong_pc_i)], wrong_pc_i);
    assign retire_idx = hist_index(retire_pc_i);
    assign retire_hash = hash_of(hist_q[retire_idx], retire_pc_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < HIST_ENTRIES; i++) begin
                hist_q[i] <= '0;
            end
            for (int j = 0; j < PHT_ENTRIES; j++) begin
                pht_q[j] <= '0;
            end
        end else if (resolve_i) begin
            hist_q[retire_idx] <= {hist_q[retire_idx][HIST_LEN-2:0], taken_i};
            // saturating train under the history before the shift
            if (taken_i && pht_q[retire_hash] != {CTR_W{1'b1}}) begin
                pht_q[retire_hash] <= pht_q[retire_hash] + CTR_W'(1);
            end else if (!taken_i && pht_q[retire_hash] != '0) begin
                pht_q[retire_hash] <= pht_q[retire_hash] - CTR_W'(1);
            end
        end
    end

endmodule

//--- verilog/bpu_pkg.sv
package bpu_pkg;

    // address and counter widths shared by every block
    localparam int ADDR_W = 32;
    localparam int CTR_W = 2;

    // what the target buffer knows about one instruction
    typedef enum logic [2:0] {
        // not a branch, or unknown
        br_none     = 3'd0,
        // conditional direct branch
        br_cond     = 3'd1,
        // unconditional direct jump
        br_direct   = 3'd2,
        // call, pushes its return address
        br_call     = 3'd3,
        // return, target from the stack
        br_ret      = 3'd4,
        // register jump, target from the target cache
        br_indirect = 3'd5
    } branch_kind_t;

endpackage
